//--- logic/soc_ctrl_defines.svh
`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define CSR_ADDR_W 14
`define CSR_DATA_W 32
`define WB_ADR_W 32

// ----------------------------------------
// Address decode fields
// ----------------------------------------
// Bits 30:29 of the byte address, bit 31 is a shadow
`define CSR_WINDOW 2'b11
// Null pointer guard field
`define NULL_GUARD_MSB 30
`define NULL_GUARD_LSB 18
// CSR bank of the system controller
`define SYSCTL_BANK 4'd1

// GPIO counts
`define GPIO_IN_W 7
`define GPIO_OUT_W 2

// Reset timing in sys_clk cycles
`define FLASH_RST_CYCLES 16
`define SYS_RST_CYCLES 64

`define SYSTEM_ID 32'h11004D31

`endif

//--- logic/soc_ctrl_pkg.sv
`default_nettype none
`include "soc_ctrl_defines.svh"

package soc_ctrl_pkg;

	typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [`CSR_DATA_W-1:0] csr_data_t;

	// Wishbone to CSR bridge sequence
	typedef enum logic [1:0] {
		BRG_IDLE    = 2'd0,
		BRG_ACCESS  = 2'd1,
		BRG_CAPTURE = 2'd2,
		BRG_ACK     = 2'd3
	} bridge_state_e;

	// Register index in csr_a[3:0]
	typedef enum logic [3:0] {
		REG_GPIO_IN       = 4'd0,
		REG_GPIO_OUT      = 4'd1,
		REG_GPIO_IRQ_EN   = 4'd2,
		REG_TIMER_CTRL    = 4'd3,
		REG_TIMER_COMPARE = 4'd4,
		REG_TIMER_COUNTER = 4'd5,
		REG_HARD_RESET    = 4'd6,
		REG_SYSTEM_ID     = 4'd7
	} sysctl_reg_e;

endpackage

`default_nettype wire

//--- logic/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defines.svh"

module reset_sequencer (
	input  wire       sys_clk,
	input  wire       trigger_reset,
	input  wire       hard_reset_i,
	input  wire [2:0] btn_i,
	output logic      sys_rst_o,
	output logic      flash_rst_n_o,
	output logic      periph_rst_n_o
);

	localparam int FLASH_CNT_W = $clog2(`FLASH_RST_CYCLES + 1);
	localparam int SYS_CNT_W   = $clog2(`SYS_RST_CYCLES + 1);

	logic                   trigger_q;
	logic [FLASH_CNT_W-1:0] flash_cnt;
	logic [SYS_CNT_W-1:0]   sys_cnt;

	// External reset, three-button chord or software reset
	always_ff @(posedge sys_clk) begin
		trigger_q <= trigger_reset | hard_reset_i | (&btn_i);
	end

	// Both counters reload while the trigger is held
	always_ff @(posedge sys_clk) begin
		if (trigger_q) begin
			flash_cnt <= FLASH_CNT_W'(`FLASH_RST_CYCLES);
			sys_cnt   <= SYS_CNT_W'(`SYS_RST_CYCLES);
		end else begin
			if (flash_cnt != '0)
				flash_cnt <= flash_cnt - 1'b1;
			if (sys_cnt != '0)
				sys_cnt <= sys_cnt - 1'b1;
		end
	end

	// Flash leaves reset first, so it is ready before the bus
	always_ff @(posedge sys_clk) begin
		flash_rst_n_o  <= ~trigger_q & (flash_cnt == '0);
		sys_rst_o      <= trigger_q | (sys_cnt != '0);
		// Peripherals follow one cycle behind the system reset
		periph_rst_n_o <= ~sys_rst_o;
	end

endmodule

`default_nettype wire

//--- logic/wb_csr_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defines.svh"

module wb_csr_bridge import soc_ctrl_pkg::*; (
	input  wire                  sys_clk,
	input  wire                  sys_rst_i,
	input  wire                  wb_cyc_i,
	input  wire                  wb_stb_i,
	input  wire                  wb_we_i,
	input  wire [`WB_ADR_W-1:0]  wb_adr_i,
	input  wire csr_data_t       wb_dat_i,
	output csr_data_t            wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 wb_err_o,
	output csr_addr_t            csr_a_o,
	output logic                 csr_we_o,
	output csr_data_t            csr_dw_o,
	input  wire csr_data_t       csr_dr_i
);

	bridge_state_e state;
	logic          accept;
	logic          req_win;
	logic          req_null;
	logic          win_q;
	logic          null_q;

	// New request only taken in idle
	assign accept   = (state == BRG_IDLE) & wb_cyc_i & wb_stb_i;
	// Bit 31 ignored, 0xE000_0000 aliases the window
	assign req_win  = wb_adr_i[30:29] == `CSR_WINDOW;
	assign req_null = wb_adr_i[`NULL_GUARD_MSB:`NULL_GUARD_LSB] == '0;

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= BRG_IDLE;
			win_q    <= 1'b0;
			null_q   <= 1'b0;
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			// Write strobe lasts one cycle
			csr_we_o <= 1'b0;
			case (state)
				BRG_IDLE: begin
					if (accept) begin
						// Decode checked once, at acceptance
						win_q    <= req_win & ~req_null;
						null_q   <= req_null;
						csr_we_o <= wb_we_i & req_win & ~req_null;
						state    <= BRG_ACCESS;
					end
				end
				// Slave registers its read data here
				BRG_ACCESS: state <= BRG_CAPTURE;
				BRG_CAPTURE: begin
					wb_ack_o <= 1'b1;
					wb_err_o <= null_q;
					state    <= BRG_ACK;
				end
				BRG_ACK: begin
					wb_ack_o <= 1'b0;
					wb_err_o <= 1'b0;
					state    <= BRG_IDLE;
				end
				default: state <= BRG_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Address and data path
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			// Word address into the CSR space
			csr_a_o  <= wb_adr_i[`CSR_ADDR_W+1:2];
			csr_dw_o <= wb_dat_i;
		end
		// Outside the window reads as zero
		if (state == BRG_CAPTURE)
			wb_dat_o <= win_q ? csr_dr_i : '0;
	end

endmodule

`default_nettype wire

//--- logic/sys_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sys_timer import soc_ctrl_pkg::*; (
	input  wire            sys_clk,
	input  wire            sys_rst_i,
	input  wire            ctrl_we_i,
	input  wire            compare_we_i,
	input  wire            counter_we_i,
	input  wire csr_data_t wdata_i,
	output logic           enable_o,
	output logic           autorestart_o,
	output csr_data_t      compare_o,
	output csr_data_t      counter_o,
	output logic           irq_o
);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			enable_o      <= 1'b0;
			autorestart_o <= 1'b0;
			compare_o     <= '0;
			counter_o     <= '0;
			irq_o         <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (counter_we_i) begin
				counter_o <= wdata_i;
			end else if (enable_o) begin
				if (counter_o == compare_o) begin
					// Match, pulse and wrap
					irq_o     <= 1'b1;
					counter_o <= '0;
					// One-shot mode stops here
					if (!autorestart_o)
						enable_o <= 1'b0;
				end else begin
					counter_o <= counter_o + 1'b1;
				end
			end
			if (compare_we_i)
				compare_o <= wdata_i;
			// Software write wins over the one-shot clear
			if (ctrl_we_i) begin
				enable_o      <= wdata_i[0];
				autorestart_o <= wdata_i[1];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/csr_sysctl.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defines.svh"

module csr_sysctl import soc_ctrl_pkg::*; (
	input  wire                   sys_clk,
	input  wire                   sys_rst_i,
	input  wire csr_addr_t        csr_a_i,
	input  wire                   csr_we_i,
	input  wire csr_data_t        csr_dw_i,
	output csr_data_t             csr_dr_o,
	input  wire [`GPIO_IN_W-1:0]  gpio_in_i,
	output logic [`GPIO_OUT_W-1:0] gpio_out_o,
	output logic                  gpio_irq_o,
	output logic                  timer_irq_o,
	output logic                  hard_reset_o
);

	logic                  bank_sel;
	logic                  wr_en;
	sysctl_reg_e           reg_idx;
	logic [`GPIO_IN_W-1:0] gpio_meta;
	logic [`GPIO_IN_W-1:0] gpio_sync;
	logic [`GPIO_IN_W-1:0] gpio_prev;
	logic [`GPIO_IN_W-1:0] irq_en_q;
	logic                  timer_enable;
	logic                  timer_autorestart;
	csr_data_t             timer_compare;
	csr_data_t             timer_counter;
	csr_data_t             rdata;

	// Bank in the top four address bits
	assign bank_sel = csr_a_i[`CSR_ADDR_W-1:`CSR_ADDR_W-4] == `SYSCTL_BANK;
	assign reg_idx  = sysctl_reg_e'(csr_a_i[3:0]);
	assign wr_en    = csr_we_i & bank_sel;

	// ----------------------------------------
	// GPIO
	// ----------------------------------------
	// Two-stage synchronizer, third stage for change detect
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_in_i;
		gpio_sync <= gpio_meta;
		gpio_prev <= gpio_sync;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o   <= '0;
			irq_en_q     <= '0;
			gpio_irq_o   <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			// Any enabled bit that toggled
			gpio_irq_o   <= |((gpio_sync ^ gpio_prev) & irq_en_q);
			// Data written is ignored, the strobe alone resets
			hard_reset_o <= wr_en & (reg_idx == REG_HARD_RESET);
			if (wr_en && reg_idx == REG_GPIO_OUT)
				gpio_out_o <= csr_dw_i[`GPIO_OUT_W-1:0];
			if (wr_en && reg_idx == REG_GPIO_IRQ_EN)
				irq_en_q <= csr_dw_i[`GPIO_IN_W-1:0];
		end
	end

	// ----------------------------------------
	// Timer
	// ----------------------------------------
	sys_timer u_timer (
		.sys_clk       (sys_clk),
		.sys_rst_i     (sys_rst_i),
		.ctrl_we_i     (wr_en & (reg_idx == REG_TIMER_CTRL)),
		.compare_we_i  (wr_en & (reg_idx == REG_TIMER_COMPARE)),
		.counter_we_i  (wr_en & (reg_idx == REG_TIMER_COUNTER)),
		.wdata_i       (csr_dw_i),
		.enable_o      (timer_enable),
		.autorestart_o (timer_autorestart),
		.compare_o     (timer_compare),
		.counter_o     (timer_counter),
		.irq_o         (timer_irq_o)
	);

	// Read mux, zero for other banks and holes
	always_comb begin
		rdata = '0;
		if (bank_sel) begin
			case (reg_idx)
				REG_GPIO_IN:       rdata[`GPIO_IN_W-1:0] = gpio_sync;
				REG_GPIO_OUT:      rdata[`GPIO_OUT_W-1:0] = gpio_out_o;
				REG_GPIO_IRQ_EN:   rdata[`GPIO_IN_W-1:0] = irq_en_q;
				REG_TIMER_CTRL:    rdata[1:0] = {timer_autorestart, timer_enable};
				REG_TIMER_COMPARE: rdata = timer_compare;
				REG_TIMER_COUNTER: rdata = timer_counter;
				REG_SYSTEM_ID:     rdata = `SYSTEM_ID;
				default:           rdata = '0;
			endcase
		end
	end

	// Registered one cycle after the address
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= rdata;
	end

endmodule

`default_nettype wire

//--- logic/soc_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defines.svh"

module soc_ctrl_top import soc_ctrl_pkg::*; (
	input  wire                    sys_clk,
	input  wire                    trigger_reset,
	input  wire [2:0]              btn_i,
	input  wire [3:0]              pcb_rev_i,
	input  wire                    wb_cyc_i,
	input  wire                    wb_stb_i,
	input  wire                    wb_we_i,
	input  wire [`WB_ADR_W-1:0]    wb_adr_i,
	input  wire csr_data_t         wb_dat_i,
	output csr_data_t              wb_dat_o,
	output logic                   wb_ack_o,
	output logic                   wb_err_o,
	output logic [`GPIO_OUT_W-1:0] leds_o,
	output logic                   gpio_irq_o,
	output logic                   timer_irq_o,
	output logic                   flash_rst_n_o,
	output logic                   periph_rst_n_o
);

	logic      sys_rst;
	logic      hard_reset;
	csr_addr_t csr_a;
	logic      csr_we;
	csr_data_t csr_dw;
	csr_data_t csr_dr;

	// ----------------------------------------
	// Reset generation
	// ----------------------------------------
	reset_sequencer u_rst (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.hard_reset_i   (hard_reset),
		.btn_i          (btn_i),
		.sys_rst_o      (sys_rst),
		.flash_rst_n_o  (flash_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// ----------------------------------------
	// Wishbone to CSR
	// ----------------------------------------
	wb_csr_bridge u_brg (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.wb_err_o  (wb_err_o),
		.csr_a_o   (csr_a),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw),
		.csr_dr_i  (csr_dr)
	);

	// Single CSR slave, no read-data OR needed
	csr_sysctl u_sysctl (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr),
		// Revision bits above the buttons
		.gpio_in_i    ({pcb_rev_i, btn_i}),
		.gpio_out_o   (leds_o),
		.gpio_irq_o   (gpio_irq_o),
		.timer_irq_o  (timer_irq_o),
		.hard_reset_o (hard_reset)
	);

endmodule

`default_nettype wire

//--- tests/soc_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_assertions (
	input wire sys_clk,
	input wire trigger_reset,
	input wire sys_rst_i,
	input wire wb_ack_i,
	input wire wb_err_i,
	input wire csr_we_i,
	input wire flash_rst_n_i
);

	// ----------------------------------------
	// Bridge handshake
	// ----------------------------------------
	// Ack drops right after one cycle
	ack_single: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o stayed high for more than one cycle");

	// Error only qualifies an ack
	err_with_ack: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		wb_err_i |-> wb_ack_i)
		else $error("wb_err_o raised without wb_ack_o");

	// CSR write strobe is a pulse
	we_single: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		csr_we_i |=> !csr_we_i)
		else $error("csr_we held for more than one cycle");

	// ----------------------------------------
	// Reset order
	// ----------------------------------------
	// Flash is out of reset whenever the system is
	flash_first: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		!sys_rst_i |-> flash_rst_n_i)
		else $error("system reset released while flash still held in reset");

endmodule

// Bridge and sequencer nets as seen at the top level
bind soc_ctrl_top soc_ctrl_assertions u_assert (
	.sys_clk       (sys_clk),
	.trigger_reset (trigger_reset),
	.sys_rst_i     (sys_rst),
	.wb_ack_i      (wb_ack_o),
	.wb_err_i      (wb_err_o),
	.csr_we_i      (csr_we),
	.flash_rst_n_i (flash_rst_n_o)
);

`default_nettype wire

//--- tests/soc_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defines.svh"

module soc_ctrl_tb;

	// Operation codes of the vector file
	localparam logic [31:0] OP_WRITE = 32'h0;
	localparam logic [31:0] OP_READ  = 32'h1;
	localparam logic [31:0] OP_ERROR = 32'h2;
	localparam logic [31:0] OP_GPIO  = 32'h3;
	localparam logic [31:0] OP_TIMER = 32'h4;
	localparam logic [31:0] OP_RESET = 32'h5;
	localparam logic [31:0] OP_LEDS  = 32'h6;
	localparam logic [31:0] OP_END   = 32'hF;
	localparam int MAX_VEC    = 64;
	localparam int VEC_CYCLES = 40;
	localparam int RST_BUDGET = `SYS_RST_CYCLES + 8;
	// Synchronizer plus change detect fits easily
	localparam int IRQ_WINDOW = 10;

	logic                   sys_clk = 1'b0;
	logic                   trigger_reset;
	logic [2:0]             btn_i;
	logic [3:0]             pcb_rev_i;
	logic                   wb_cyc_i;
	logic                   wb_stb_i;
	logic                   wb_we_i;
	logic [`WB_ADR_W-1:0]   wb_adr_i;
	logic [`CSR_DATA_W-1:0] wb_dat_i;
	logic [`CSR_DATA_W-1:0] wb_dat_o;
	logic                   wb_ack_o;
	logic                   wb_err_o;
	logic [`GPIO_OUT_W-1:0] leds_o;
	logic                   gpio_irq_o;
	logic                   timer_irq_o;
	logic                   flash_rst_n_o;
	logic                   periph_rst_n_o;

	// Four words per vector line
	logic [31:0] vec_mem [0:4*MAX_VEC-1];
	int          num_vec;
	int          vec_idx;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	int          check_cnt = 0;
	int          err_cnt = 0;

	soc_ctrl_top uut (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.btn_i          (btn_i),
		.pcb_rev_i      (pcb_rev_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.wb_err_o       (wb_err_o),
		.leds_o         (leds_o),
		.gpio_irq_o     (gpio_irq_o),
		.timer_irq_o    (timer_irq_o),
		.flash_rst_n_o  (flash_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// 20 ns period
	always #10 sys_clk = ~sys_clk;

	// Watchdog on the whole run
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
			$display("Checks %0d, errors %0d", check_cnt, err_cnt);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_cnt++;
		assert (actual === expected) else begin
			err_cnt++;
			$display("FAILED %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic require(input logic cond, input string msg);
		check_cnt++;
		assert (cond) else begin
			err_cnt++;
			$display("Error %s", msg);
		end
	endtask

	// ----------------------------------------
	// Bus and wait helpers
	// ----------------------------------------
	// Hold the request until ack, drop it one edge later
	task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, output logic err);
		@(posedge sys_clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= wdat;
		@(negedge sys_clk);
		while (!wb_ack_o)
			@(negedge sys_clk);
		rdat = wb_dat_o;
		err  = wb_err_o;
		@(posedge sys_clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	// High cycles of one interrupt line over a window
	task automatic count_pulses(input int cycles, input logic use_timer, output int pulses);
		pulses = 0;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (use_timer ? timer_irq_o : gpio_irq_o)
				pulses++;
		end
	endtask

	// Flash must come up strictly before the peripherals
	task automatic wait_reset_release(input int limit);
		int n;
		int flash_at;
		n = 0;
		flash_at = -1;
		while (!periph_rst_n_o && n < limit) begin
			@(negedge sys_clk);
			n++;
			if (flash_rst_n_o && flash_at < 0)
				flash_at = n;
		end
		require(periph_rst_n_o, "periph_rst_n_o was never released");
		require(flash_at >= 0 && flash_at < n, "flash reset not released before periph reset");
	endtask

	task automatic wait_hard_reset(input int limit);
		int n;
		n = 0;
		while (periph_rst_n_o && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		require(!periph_rst_n_o, "periph_rst_n_o did not go low after the hard reset write");
		wait_reset_release(limit);
	endtask

	task automatic run_vector(input logic [31:0] op, input logic [31:0] adr,
			input logic [31:0] data, input logic [31:0] expected);
		logic [31:0] rdat;
		logic        err;
		int          pulses;
		case (op)
			OP_WRITE: begin
				bus_access(1'b1, adr, data, rdat, err);
				compare_value("wb_err_o", 32'h0, 32'(err));
			end
			OP_READ: begin
				bus_access(1'b0, adr, data, rdat, err);
				compare_value("wb_err_o", 32'h0, 32'(err));
				compare_value("wb_dat_o", expected, rdat);
			end
			// Null guard write must come back with an error
			OP_ERROR: begin
				bus_access(1'b1, adr, data, rdat, err);
				compare_value("wb_err_o", 32'h1, 32'(err));
			end
			OP_GPIO: begin
				@(posedge sys_clk);
				pcb_rev_i <= data[6:3];
				btn_i     <= data[2:0];
				count_pulses(IRQ_WINDOW, 1'b0, pulses);
				compare_value("gpio_irq_o pulses", expected, 32'(pulses));
			end
			OP_TIMER: begin
				count_pulses(int'(data), 1'b1, pulses);
				compare_value("timer_irq_o pulses", expected, 32'(pulses));
			end
			OP_RESET: wait_hard_reset(int'(data));
			OP_LEDS: compare_value("leds_o", expected, 32'(leds_o));
			default: require(1'b0, "unknown operation in the vector file");
		endcase
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		trigger_reset = 1'b1;
		btn_i         = 3'b000;
		pcb_rev_i     = 4'h0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		wb_we_i       = 1'b0;
		wb_adr_i      = '0;
		wb_dat_i      = '0;
		$readmemh("tests/soc_ctrl_vectors.txt", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC && vec_mem[4*num_vec] != OP_END)
			num_vec++;
		cycle_limit = num_vec * VEC_CYCLES + RST_BUDGET;

		repeat (4) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		// Everything still held at the end of the reset pulse
		@(negedge sys_clk);
		compare_value("flash_rst_n_o", 32'h0, 32'(flash_rst_n_o));
		compare_value("periph_rst_n_o", 32'h0, 32'(periph_rst_n_o));
		compare_value("wb_ack_o", 32'h0, 32'(wb_ack_o));
		compare_value("wb_err_o", 32'h0, 32'(wb_err_o));
		compare_value("gpio_irq_o", 32'h0, 32'(gpio_irq_o));
		compare_value("timer_irq_o", 32'h0, 32'(timer_irq_o));
		compare_value("leds_o", 32'h0, 32'(leds_o));
		wait_reset_release(RST_BUDGET);

		for (vec_idx = 0; vec_idx < num_vec; vec_idx++)
			run_vector(vec_mem[4*vec_idx], vec_mem[4*vec_idx+1],
				vec_mem[4*vec_idx+2], vec_mem[4*vec_idx+3]);

		$display("Checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- soc_ctrl.f
+incdir+logic
logic/soc_ctrl_pkg.sv
logic/reset_sequencer.sv
logic/wb_csr_bridge.sv
logic/sys_timer.sv
logic/csr_sysctl.sv
logic/soc_ctrl_top.sv
tests/soc_ctrl_assertions.sv
tests/soc_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module soc_ctrl_tb -f soc_ctrl.f

sim_out=$(./obj_dir/Vsoc_ctrl_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

//--- tests/soc_ctrl_vectors.txt
// Columns are op addr data expected in hex
// Ops 0 write 1 read 2 null error 3 gpio set 4 timer wait 5 hard reset 6 leds f end
3 00000000 00000050 00000000
1 6000101C 00000000 11004D31
1 E000101C 00000000 11004D31
1 60001000 00000000 00000050
0 60001004 00000002 00000000
1 60001004 00000000 00000002
1 E0001004 00000000 00000002
6 00000000 00000000 00000002
0 60001008 00000001 00000000
1 60001008 00000000 00000001
0 60001010 00000014 00000000
1 60001010 00000000 00000014
1 E0001010 00000000 00000014
// Null pointer writes must not reach GPIO_OUT
2 00001004 00000001 00000000
2 80001004 00000003 00000000
1 60001004 00000000 00000002
1 40001004 00000000 00000000
// Button 0 enabled and button 1 masked
3 00000000 00000051 00000001
3 00000000 00000053 00000000
3 00000000 00000050 00000001
1 60001000 00000000 00000050
// One-shot timer with compare 20
0 6000100C 00000001 00000000
4 00000000 0000001E 00000001
1 6000100C 00000000 00000000
0 60001018 00000000 00000000
5 00000000 000000C8 00000000
6 00000000 00000000 00000000
1 60001004 00000000 00000000
f 00000000 00000000 00000000
